// ==== testbench/lsuTests.txt ====
# memRw funct3 funct7 atomic bigEndian stall flushW address writeData expReadData expSquash expFault
# All hex; expFault bit 1 is load misaligned, bit 0 is store/AMO misaligned
1 2 00 0 0 0 0 00000010 8899aabb 00000000 0 0
1 0 00 0 0 0 0 00000011 000000c5 00000000 0 0
1 1 00 0 0 0 0 00000012 1234f00d 00000000 0 0
2 0 00 0 0 0 0 00000011 00000000 ffffffc5 0 0
2 4 00 0 0 0 0 00000011 00000000 000000c5 0 0
2 1 00 0 0 0 0 00000012 00000000 fffff00d 0 0
2 5 00 0 0 0 0 00000012 00000000 0000f00d 0 0
2 2 00 0 0 0 0 00000010 00000000 f00dc5bb 0 0
1 2 00 0 1 0 0 00000020 11223344 00000000 0 0
2 2 00 0 0 0 0 00000020 00000000 44332211 0 0
2 0 00 0 1 0 0 00000020 00000000 00000011 0 0
1 0 00 0 1 0 0 00000021 000000ab 00000000 0 0
2 1 00 0 1 0 0 00000020 00000000 000011ab 0 0
2 2 00 0 1 0 0 00000020 00000000 11ab3344 0 0
1 2 00 0 0 0 0 00000030 00000010 00000000 0 0
3 2 00 2 0 0 0 00000030 00000005 00000010 0 0
3 2 04 2 0 0 0 00000030 80000000 00000015 0 0
3 2 10 2 0 0 0 00000030 f0000001 80000000 0 0
3 2 20 2 0 0 0 00000030 0000ff00 70000001 0 0
3 2 30 2 0 0 0 00000030 f00f0f0f 7000ff01 0 0
3 2 40 2 0 0 0 00000030 fffffffe 70000f01 0 0
3 2 50 2 0 0 0 00000030 00000003 fffffffe 0 0
3 2 60 2 0 0 0 00000030 ffffffff 00000003 0 0
3 2 70 2 0 0 0 00000030 80000000 00000003 0 0
2 2 00 0 0 0 0 00000030 00000000 80000000 0 0
1 2 00 0 0 0 0 00000040 00000001 00000000 0 0
2 2 00 1 0 0 0 00000040 00000000 00000001 0 0
1 2 00 1 0 0 0 00000040 000000aa 00000000 0 0
1 2 00 1 0 0 0 00000040 000000bb 00000000 1 0
2 2 00 0 0 0 0 00000040 00000000 000000aa 0 0
2 2 00 1 0 0 0 00000040 00000000 000000aa 0 0
1 2 00 1 0 0 0 00000044 00000077 00000000 1 0
1 2 00 0 0 0 0 00000050 5555aaaa 00000000 0 0
2 1 00 0 0 0 0 00000051 00000000 00000000 0 2
2 2 00 0 0 0 0 00000052 00000000 00000000 0 2
1 2 00 0 0 0 0 00000052 12345678 00000000 0 1
3 2 00 2 0 0 0 00000051 00000001 00000000 0 1
2 2 00 0 0 0 0 00000050 00000000 5555aaaa 0 0
1 2 00 0 0 0 0 00000060 0badf00d 00000000 0 0
1 2 00 0 0 0 0 00000064 11111111 00000000 0 0
2 2 00 0 0 0 0 00000064 00000000 11111111 0 0
2 2 00 0 0 1 0 00000060 00000000 11111111 0 0
1 2 00 0 0 1 0 00000060 deadbeef 00000000 0 0
2 2 00 0 0 0 0 00000060 00000000 0badf00d 0 0
1 2 00 0 0 0 1 00000060 cccccccc 00000000 0 0
2 2 00 0 0 0 0 00000060 00000000 0badf00d 0 0

// ==== build.f ====
rtl/lsuPkg.sv
rtl/amoAlu.sv
rtl/atomic.sv
rtl/dtim.sv
rtl/subwordRead.sv
rtl/subwordWrite.sv
rtl/lsu.sv
testbench/tbClock.sv
testbench/lsuChecker.sv
testbench/tbLsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - rtl/lsuPkg.sv
      - rtl/amoAlu.sv
      - rtl/atomic.sv
      - rtl/dtim.sv
      - rtl/subwordRead.sv
      - rtl/subwordWrite.sv
      - rtl/lsu.sv
  - target: simulation
    files:
      - testbench/tbClock.sv
      - testbench/lsuChecker.sv
      - testbench/tbLsu.sv

// ==== testbench/tbLsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbLsu;

  typedef struct packed {
    lsuPkg::memRwT  rw;
    lsuPkg::funct3T f3;
    lsuPkg::funct7T f7;
    lsuPkg::atomicT at;
    logic           be;
    logic           stall;              // stallM and stallW together
    logic           flush;              // flushW
    lsuPkg::wordT   adr;
    lsuPkg::wordT   wdata;
    lsuPkg::wordT   expRd;
    logic           expSq;
    logic [1:0]     expFlt;
  } opT;

  logic clk;
  logic rstN;
  logic stallM, flushM, stallW, flushW, bigEndianM, squashScW;
  logic loadMisalignedFaultM, storeAmoMisalignedFaultM;
  lsuPkg::memRwT  memRwM;
  lsuPkg::funct3T funct3M;
  lsuPkg::funct7T funct7M;
  lsuPkg::atomicT atomicM;
  lsuPkg::wordT   ieuAdrE, ieuAdrM, writeDataM, readDataW;
  logic           expValid, expCheckRead, expSquash;
  logic [1:0]     expFault;
  lsuPkg::wordT   expReadData;
  lsuPkg::wordT   expAdr;
  opT             ops[$];
  int             fileErrors = 0;
  int             checkErrors;
  int             totalErrors;
  int             cycleCount = 0;
  int             timeoutLimit = 0;

  tbClock i_tbClock (.clk(clk), .rstN(rstN));

  lsu #(.dtimAdrBits(8)) i_lsu (
    .clk(clk), .rstN(rstN), .stallM(stallM), .flushM(flushM), .stallW(stallW),
    .flushW(flushW), .memRwM(memRwM), .funct3M(funct3M), .funct7M(funct7M),
    .atomicM(atomicM), .bigEndianM(bigEndianM), .ieuAdrE(ieuAdrE), .ieuAdrM(ieuAdrM),
    .writeDataM(writeDataM), .readDataW(readDataW), .squashScW(squashScW),
    .loadMisalignedFaultM(loadMisalignedFaultM),
    .storeAmoMisalignedFaultM(storeAmoMisalignedFaultM)
  );

  lsuChecker i_lsuChecker (
    .clk(clk), .rstN(rstN), .expValid(expValid), .expCheckRead(expCheckRead),
    .expAdr(expAdr), .expReadData(expReadData), .expSquash(expSquash),
    .expFault(expFault), .ieuAdrM(ieuAdrM), .readDataW(readDataW),
    .squashScW(squashScW), .loadMisalignedFaultM(loadMisalignedFaultM),
    .storeAmoMisalignedFaultM(storeAmoMisalignedFaultM), .errorCount(checkErrors)
  );

  task automatic setIdle();
    {memRwM, funct3M, funct7M, atomicM} = '0;
    {bigEndianM, stallM, stallW, flushW, flushM} = '0;
    writeDataM = '0;
    expValid   = 1'b0;                  // Nothing due from the checker
  endtask

  //////////////////////////////////////////////////
  // Test file
  //////////////////////////////////////////////////

  task automatic readTests();
    int          fd;
    int          count;
    string       line;
    logic [31:0] col [12];
    opT          op;
    fd = $fopen("testbench/lsuTests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test file testbench/lsuTests.txt");
      fileErrors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue; // Blank or comment
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                      col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9],
                      col[10], col[11]);
      if (count != 12) begin
        $display("Test file line has %0d of 12 fields: %s", count, line);
        fileErrors++;
      end else begin
        op = {col[0][1:0], col[1][2:0], col[2][6:0], col[3][1:0], col[4][0], col[5][0],
              col[6][0], col[7], col[8], col[9], col[10][0], col[11][1:0]};
        ops.push_back(op);
      end
    end
    $fclose(fd);
    if (ops.size() == 0 && fileErrors == 0) begin
      $display("The test file holds no operations");
      fileErrors++;
    end
  endtask

  // Address goes out one cycle ahead of its M controls, back to back.
  // A stalled line holds ieuAdrM, so the line after it reuses its address
  task automatic runOps();
    lsuPkg::wordT heldAdr;              // Address the M register should hold
    wait (rstN);
    @(posedge clk);
    #1 ieuAdrE = ops[0].adr;
    for (int i = 0; i < ops.size(); i++) begin
      @(posedge clk);
      #1;
      memRwM       = ops[i].rw;
      funct3M      = ops[i].f3;
      funct7M      = ops[i].f7;
      atomicM      = ops[i].at;
      bigEndianM   = ops[i].be;
      stallM       = ops[i].stall;
      stallW       = ops[i].stall;
      flushW       = ops[i].flush;
      writeDataM   = ops[i].wdata;
      ieuAdrE      = (i + 1 < ops.size()) ? ops[i+1].adr : '0;
      if (i == 0 || !ops[i-1].stall) heldAdr = ops[i].adr; // stallM blocks the capture
      expAdr       = heldAdr;
      expValid     = 1'b1;
      expCheckRead = ops[i].rw[1] && (ops[i].expFlt == 2'b00); // Loads, AMO, LR
      expReadData  = ops[i].expRd;
      expSquash    = ops[i].expSq;
      expFault     = ops[i].expFlt;
    end
    @(posedge clk);
    #1 setIdle();
  endtask

  initial begin
    setIdle();
    ieuAdrE = '0;
    expAdr  = '0;
    {expCheckRead, expSquash, expFault, expReadData} = '0;
    readTests();
    timeoutLimit = 2 * ops.size() + 20;
    if (fileErrors == 0) runOps();
    repeat (3) @(posedge clk);          // Let the last W check happen
    totalErrors = fileErrors + checkErrors;
    $display("Errors: %0d compare, %0d test file", checkErrors, fileErrors);
    if (totalErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Run length guard
  always @(posedge clk) begin
    cycleCount++;
    if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
      $display("Timeout, the run did not end within %0d cycles", timeoutLimit);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/lsuChecker.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsuChecker (
  input  logic         clk,
  input  logic         rstN,
  input  logic         expValid,        // An operation is in M this cycle
  input  logic         expCheckRead,    // Its readDataW is worth comparing
  input  lsuPkg::wordT expAdr,          // Address due on ieuAdrM in M
  input  lsuPkg::wordT expReadData,
  input  logic         expSquash,
  input  logic [1:0]   expFault,        // Bit 1 load, bit 0 store/AMO
  input  lsuPkg::wordT ieuAdrM,
  input  lsuPkg::wordT readDataW,
  input  logic         squashScW,
  input  logic         loadMisalignedFaultM,
  input  logic         storeAmoMisalignedFaultM,
  output int           errorCount
);

  logic         pending;                // Previous M cycle had an operation
  logic         pendRead;
  lsuPkg::wordT pendReadData;
  logic         pendSquash;

  initial begin
    errorCount = 0;
    pending    = 1'b0;
  end

  task automatic reportMismatch(input string name, input lsuPkg::wordT expVal,
                                input lsuPkg::wordT gotVal);
    $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, expVal, gotVal);
    errorCount++;
  endtask

  //////////////////////////////////////////////////
  // Compare mid-cycle, away from both clock edges
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rstN) begin
      // W stage results of last cycle's operation
      if (pending) begin
        if (pendRead && (readDataW !== pendReadData))
          reportMismatch("readDataW", pendReadData, readDataW);
        if (squashScW !== pendSquash)
          reportMismatch("squashScW", {31'b0, pendSquash}, {31'b0, squashScW});
      end
      pending      = expValid;
      pendRead     = expCheckRead;
      pendReadData = expReadData;
      pendSquash   = expSquash;
      // Address register and faults, both visible in M
      if (expValid) begin
        if (ieuAdrM !== expAdr)
          reportMismatch("ieuAdrM", expAdr, ieuAdrM);
        if (loadMisalignedFaultM !== expFault[1])
          reportMismatch("loadMisalignedFaultM", {31'b0, expFault[1]},
                         {31'b0, loadMisalignedFaultM});
        if (storeAmoMisalignedFaultM !== expFault[0])
          reportMismatch("storeAmoMisalignedFaultM", {31'b0, expFault[0]},
                         {31'b0, storeAmoMisalignedFaultM});
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tbClock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
  parameter int resetCycles = 5         // Edges with rstN held low
) (
  output logic clk,
  output logic rstN
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 rstN = 1'b1;                     // Release off the edge
  end

endmodule

`default_nettype wire

// ==== rtl/lsu.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu #(
  parameter int dtimAdrBits = 8                   // Word address bits of the DTIM
) (
  input  logic             clk,
  input  logic             rstN,
  input  logic             stallM,
  input  logic             flushM,
  input  logic             stallW,
  input  logic             flushW,
  input  lsuPkg::memRwT    memRwM,                // 10 read, 01 write, 11 AMO
  input  lsuPkg::funct3T   funct3M,               // Size and sign of the access
  input  lsuPkg::funct7T   funct7M,               // AMO function
  input  lsuPkg::atomicT   atomicM,               // AMO or LR/SC marker
  input  logic             bigEndianM,            // Memory is big-endian
  input  lsuPkg::wordT     ieuAdrE,               // Address from execute
  output lsuPkg::wordT     ieuAdrM,               // Address in memory stage
  input  lsuPkg::wordT     writeDataM,            // Store operand
  output lsuPkg::wordT     readDataW,             // Load result to writeback
  output logic             squashScW,             // SC failed, no GPR success
  output logic             loadMisalignedFaultM,
  output logic             storeAmoMisalignedFaultM
);

  lsuPkg::memRwT    preRwM;         // Request after fault and flush gating
  lsuPkg::memRwT    lsuRwM;         // Request after SC gating
  lsuPkg::wordT     amoWriteDataM;  // Store operand or AMO result
  lsuPkg::wordT     lsuWriteDataM;  // Replicated and endian-swapped word
  lsuPkg::byteMaskT byteMaskM;
  lsuPkg::wordT     readWordM;      // Raw DTIM word
  lsuPkg::wordT     readDataM;      // Extended load value
  logic [1:0]       sizeM;
  logic             halfMisM;
  logic             wordMisM;
  logic             misalignedM;
  logic             dtimWriteEn;

  //////////////////////////////////////////////////
  // E to M address register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ieuAdrM <= '0;
    end else if (flushM) begin
      ieuAdrM <= '0;                              // Bubble into M
    end else if (!stallM) begin
      ieuAdrM <= ieuAdrE;
    end
  end

  //////////////////////////////////////////////////
  // Misalignment and request gating
  //////////////////////////////////////////////////

  assign sizeM    = funct3M[1:0];
  assign halfMisM = (sizeM == lsuPkg::sizeHalf) & ieuAdrM[0];
  // Atomics are always word accesses
  assign wordMisM = ((sizeM == lsuPkg::sizeWord) | (|atomicM)) & (|ieuAdrM[1:0]);
  assign misalignedM = halfMisM | wordMisM;

  assign loadMisalignedFaultM     = misalignedM & (memRwM == lsuPkg::rwRead);
  assign storeAmoMisalignedFaultM = misalignedM & memRwM[0]; // Stores, SC and AMOs

  // Faulting or flushed accesses become idle
  assign preRwM = (loadMisalignedFaultM | storeAmoMisalignedFaultM | flushW) ?
                  lsuPkg::rwIdle : memRwM;

  atomic i_atomic (
    .clk           (clk),
    .rstN          (rstN),
    .stallW        (stallW),
    .preRwM        (preRwM),
    .atomicM       (atomicM),
    .funct7M       (funct7M),
    .adrM          (ieuAdrM),
    .readDataM     (readDataM),
    .writeDataM    (writeDataM),
    .lsuRwM        (lsuRwM),
    .amoWriteDataM (amoWriteDataM),
    .squashScW     (squashScW)
  );

  //////////////////////////////////////////////////
  // Store path, DTIM and load path
  //////////////////////////////////////////////////

  subwordWrite i_subwordWrite (
    .writeDataIn (amoWriteDataM),
    .byteOffset  (ieuAdrM[1:0]),
    .bigEndian   (bigEndianM),
    .funct3      (funct3M),
    .writeData   (lsuWriteDataM),
    .byteMask    (byteMaskM)
  );

  assign dtimWriteEn = lsuRwM[0] & ~stallW;      // Write lands at the edge ending M

  dtim #(.adrBits(dtimAdrBits)) i_dtim (
    .clk       (clk),
    .writeEn   (dtimWriteEn),
    .adr       (ieuAdrM[dtimAdrBits+1:2]),
    .byteMask  (byteMaskM),
    .writeData (lsuWriteDataM),
    .readData  (readWordM)
  );

  subwordRead i_subwordRead (
    .wordIn     (readWordM),
    .byteOffset (ieuAdrM[1:0]),
    .bigEndian  (bigEndianM),
    .funct3     (funct3M),
    .readData   (readDataM)
  );

  // M to W read data register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) readDataW <= '0;
    else if (!stallW) readDataW <= readDataM;    // Holds while W stalls
  end

  // A fault must never reach the memory, even through the SC path
  assert property (@(posedge clk) disable iff (!rstN)
    (loadMisalignedFaultM | storeAmoMisalignedFaultM) |-> !dtimWriteEn);

endmodule

`default_nettype wire

// ==== rtl/subwordWrite.sv ====
`timescale 1ns/10ps
`default_nettype none

module subwordWrite (
  input  lsuPkg::wordT     writeDataIn, // Store operand or AMO result
  input  logic [1:0]       byteOffset,
  input  logic             bigEndian,
  input  lsuPkg::funct3T   funct3,
  output lsuPkg::wordT     writeData,   // Word to memory
  output lsuPkg::byteMaskT byteMask
);

  lsuPkg::wordT repWord;                // Subword copied to every lane

  //////////////////////////////////////////////////
  // Replication and mask
  //////////////////////////////////////////////////

  always_comb begin
    case (funct3[1:0])
      lsuPkg::sizeByte: begin
        repWord  = {4{writeDataIn[7:0]}};
        byteMask = 4'b0001 << byteOffset;
      end
      lsuPkg::sizeHalf: begin
        repWord  = {2{writeDataIn[15:0]}};
        byteMask = byteOffset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        repWord  = writeDataIn;
        byteMask = 4'b1111;
      end
    endcase
  end

  // Swap lanes only, the mask already names byte addresses
  assign writeData = bigEndian ? lsuPkg::swapBytes(repWord) : repWord;

endmodule

`default_nettype wire

// ==== rtl/subwordRead.sv ====
`timescale 1ns/10ps
`default_nettype none

module subwordRead (
  input  lsuPkg::wordT   wordIn,      // Raw word from memory
  input  logic [1:0]     byteOffset,  // Address bits 1..0
  input  logic           bigEndian,
  input  lsuPkg::funct3T funct3,
  output lsuPkg::wordT   readData     // Extended load value
);

  lsuPkg::wordT leWord;               // Word in little-endian lane order
  logic [1:0]   offset;
  logic [7:0]   byteVal;
  logic [15:0]  halfVal;
  logic         isUnsigned;

  //////////////////////////////////////////////////
  // Endian swap
  //////////////////////////////////////////////////

  assign leWord = bigEndian ? lsuPkg::swapBytes(wordIn) : wordIn;
  assign offset = bigEndian ? ~byteOffset : byteOffset; // Lanes moved by the swap

  // Subword select
  assign byteVal = leWord[offset*8 +: 8];
  assign halfVal = offset[1] ? leWord[31:16] : leWord[15:0];

  assign isUnsigned = funct3[2];      // lbu, lhu

  always_comb begin
    case (funct3[1:0])
      lsuPkg::sizeByte: begin
        readData = {{24{byteVal[7] & ~isUnsigned}}, byteVal};
      end
      lsuPkg::sizeHalf: begin
        readData = {{16{halfVal[15] & ~isUnsigned}}, halfVal};
      end
      default: begin
        readData = leWord;            // lw, AMO, LR
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/dtim.sv ====
`timescale 1ns/10ps
`default_nettype none

module dtim #(
  parameter int adrBits = 8             // Word address width
) (
  input  logic               clk,
  input  logic               writeEn,
  input  logic [adrBits-1:0] adr,       // Word address
  input  logic [3:0]         byteMask,  // Lane 0 is the lowest byte address
  input  logic [31:0]        writeData,
  output logic [31:0]        readData
);

  logic [31:0] mem [2**adrBits];

  // Combinational read of the addressed word
  assign readData = mem[adr];

  //////////////////////////////////////////////////
  // Byte-masked write
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int i = 0; i < 4; i++) begin
        if (byteMask[i]) mem[adr][i*8 +: 8] <= writeData[i*8 +: 8];
      end
    end
  end

  // A write with no lanes enabled means the mask logic went wrong
  assert property (@(posedge clk) writeEn |-> (|byteMask));

endmodule

`default_nettype wire

// ==== rtl/atomic.sv ====
`timescale 1ns/10ps
`default_nettype none

module atomic (
  input  logic           clk,
  input  logic           rstN,
  input  logic           stallW,
  input  lsuPkg::memRwT  preRwM,        // Gated request from lsu
  input  lsuPkg::atomicT atomicM,
  input  lsuPkg::funct7T funct7M,
  input  lsuPkg::wordT   adrM,          // Physical address
  input  lsuPkg::wordT   readDataM,     // Old word, as loaded
  input  lsuPkg::wordT   writeDataM,    // rs2 operand
  output lsuPkg::memRwT  lsuRwM,        // Final request
  output lsuPkg::wordT   amoWriteDataM,
  output logic           squashScW
);

  lsuPkg::wordT amoResultM;
  logic [29:0]  resAdr;                 // Reserved word address
  logic         resValid;
  logic         lrM;
  logic         scM;
  logic         resMatchM;
  logic         scFailM;

  //////////////////////////////////////////////////
  // LR/SC reservation
  //////////////////////////////////////////////////

  assign lrM = atomicM[0] & (preRwM == lsuPkg::rwRead);
  assign scM = atomicM[0] & (preRwM == lsuPkg::rwWrite);

  assign resMatchM = resValid & (resAdr == adrM[31:2]);
  assign scFailM   = scM & ~resMatchM;

  // A failing SC turns into an idle cycle
  assign lsuRwM = scFailM ? lsuPkg::rwIdle : preRwM;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resValid  <= 1'b0;
      resAdr    <= '0;
      squashScW <= 1'b0;
    end else if (!stallW) begin
      squashScW <= scFailM;
      if (lrM) begin
        resValid <= 1'b1;               // New reservation replaces the old
        resAdr   <= adrM[31:2];
      end else if (scM) begin
        resValid <= 1'b0;               // Any SC consumes it
      end
    end
  end

  //////////////////////////////////////////////////
  // AMO write data
  //////////////////////////////////////////////////

  amoAlu i_amoAlu (
    .op (funct7M[6:2]),
    .a  (readDataM),
    .b  (writeDataM),
    .y  (amoResultM)
  );

  assign amoWriteDataM = atomicM[1] ? amoResultM : writeDataM;

  // Only an AMO may issue a read-modify-write
  assert property (@(posedge clk) disable iff (!rstN)
    (lsuRwM == lsuPkg::rwAmo) |-> atomicM[1]);

endmodule

`default_nettype wire

// ==== rtl/amoAlu.sv ====
`timescale 1ns/10ps
`default_nettype none

module amoAlu (
  input  logic [4:0]   op,        // funct7[6:2]
  input  lsuPkg::wordT a,         // Old memory word
  input  lsuPkg::wordT b,         // rs2 operand
  output lsuPkg::wordT y
);

  logic aLtSigned;
  logic aLtUnsigned;

  assign aLtSigned   = $signed(a) < $signed(b);
  assign aLtUnsigned = a < b;

  //////////////////////////////////////////////////
  // Operation select
  //////////////////////////////////////////////////

  always_comb begin
    case (op)
      lsuPkg::amoSwap: begin
        y = b;
      end
      lsuPkg::amoAdd: begin
        y = a + b;                    // Wraps, no overflow flag
      end
      lsuPkg::amoXor: begin
        y = a ^ b;
      end
      lsuPkg::amoAnd: begin
        y = a & b;
      end
      lsuPkg::amoOr: begin
        y = a | b;
      end
      lsuPkg::amoMin: begin
        y = aLtSigned ? a : b;
      end
      lsuPkg::amoMax: begin
        y = aLtSigned ? b : a;        // Equal values give a, same word
      end
      lsuPkg::amoMinu: begin
        y = aLtUnsigned ? a : b;
      end
      lsuPkg::amoMaxu: begin
        y = aLtUnsigned ? b : a;
      end
      default: begin
        y = b;                        // Unknown code behaves as swap
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/lsuPkg.sv ====
`default_nettype none

package lsuPkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [31:0] wordT;     // Data or address word
  typedef logic [3:0]  byteMaskT; // One enable per byte lane
  typedef logic [1:0]  memRwT;    // Read in bit 1, write in bit 0
  typedef logic [2:0]  funct3T;   // Size in 1:0, unsigned flag in bit 2
  typedef logic [6:0]  funct7T;   // AMO select in 6:2, aq/rl in 1:0
  typedef logic [1:0]  atomicT;   // Bit 1 AMO, bit 0 LR/SC

  // Read/write request codes
  localparam memRwT rwIdle  = 2'b00;
  localparam memRwT rwWrite = 2'b01;
  localparam memRwT rwRead  = 2'b10;
  localparam memRwT rwAmo   = 2'b11; // Read-modify-write

  // Access size as carried in funct3[1:0]
  localparam logic [1:0] sizeByte = 2'b00;
  localparam logic [1:0] sizeHalf = 2'b01;
  localparam logic [1:0] sizeWord = 2'b10;

  // AMO funct5 codes, funct7[6:2]
  localparam logic [4:0] amoAdd  = 5'b00000;
  localparam logic [4:0] amoSwap = 5'b00001;
  localparam logic [4:0] amoXor  = 5'b00100;
  localparam logic [4:0] amoOr   = 5'b01000;
  localparam logic [4:0] amoAnd  = 5'b01100;
  localparam logic [4:0] amoMin  = 5'b10000;
  localparam logic [4:0] amoMax  = 5'b10100;
  localparam logic [4:0] amoMinu = 5'b11000;
  localparam logic [4:0] amoMaxu = 5'b11100;

  // Reverse byte order of a word, shared by load and store paths
  function automatic wordT swapBytes(input wordT w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

endpackage

`default_nettype wire
